//--- Makefile
# Verilator build and run for the refill engine testbench

VERILATOR ?= verilator
TOP       ?= tb_refill_top
SEED      ?= 130061287
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir_$(SEED)
VFLAGS    ?= --binary --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST)) refill_defines.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir_* $(LOG)

//--- flist.f
+incdir+.
refill_pkg.sv
refill_req_queue.sv
refill_bus_reader.sv
refill_line_assembler.sv
refill_top.sv
tb_wb_mem.sv
tb_refill_top.sv

//--- refill_bus_reader.sv
`timescale 1ns/100ps
`include "refill_defines.svh"

module refill_bus_reader (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       q_valid,
    input  refill_pkg::refill_req_t    q_head,
    input  logic                       wb_ack,
    input  logic [`REFILL_DATA_W-1:0]  wb_dat_i,
    output logic                       q_pop,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic [`REFILL_ADDR_W-1:0]  wb_adr,
    output logic                       beat_valid,
    output refill_pkg::refill_beat_t   beat
);
    import refill_pkg::*;

    localparam int ADDR_W     = `REFILL_ADDR_W;
    localparam int LINE_OFS_W = $clog2(`REFILL_LINE_W / 8);
    localparam int WORD_OFS_W = $clog2(`REFILL_DATA_W / 8);
    localparam int IDX_W      = $clog2(`REFILL_LINE_WORDS);

    reader_state_e      state;
    refill_kind_e       kind_q;
    logic [ADDR_W-1:0]  adr_q;
    logic [IDX_W-1:0]   idx_q;
    logic               last_beat;
    logic               ack_hit;

    // take the next request only between bus cycles
    assign q_pop = (state == ST_IDLE) && q_valid;

    assign wb_cyc = (state == ST_BUS);
    assign wb_stb = wb_cyc;
    assign wb_adr = adr_q;

    assign ack_hit   = wb_stb && wb_ack;
    assign last_beat = (kind_q == RD_WORD) || (idx_q == IDX_W'(`REFILL_LINE_WORDS - 1));

    always_ff @(posedge aclk) begin
        if (rst) begin
            state      <= ST_IDLE;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= ack_hit;
            case (state)
                ST_IDLE: begin
                    if (q_pop) begin
                        state <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    // drop cyc for a cycle after the final ack
                    if (ack_hit && last_beat) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (q_pop) begin
            kind_q <= q_head.kind;
            idx_q  <= '0;
            if (q_head.kind == RD_LINE) begin
                adr_q <= {q_head.addr[ADDR_W-1:LINE_OFS_W], LINE_OFS_W'(0)};
            end else begin
                adr_q <= {q_head.addr[ADDR_W-1:WORD_OFS_W], WORD_OFS_W'(0)};
            end
        end else if (ack_hit) begin
            adr_q      <= adr_q + ADDR_W'(`REFILL_DATA_W / 8);
            idx_q      <= idx_q + 1'b1;
            beat.data  <= wb_dat_i;
            beat.index <= idx_q;
            beat.last  <= last_beat;
        end
    end

    // word slot tracks the address within the line
    slot_matches_adr: assert property (
        @(posedge aclk) disable iff (rst)
        wb_stb && (kind_q == RD_LINE) |-> (wb_adr[LINE_OFS_W-1:WORD_OFS_W] == idx_q)
    );

    // slave may stall, address and strobe must wait for it
    adr_held: assert property (
        @(posedge aclk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr)
    );

endmodule

//--- refill_defines.svh
`ifndef REFILL_DEFINES_SVH
`define REFILL_DEFINES_SVH

// byte address and bus word
`define REFILL_ADDR_W 32
`define REFILL_DATA_W 32

// one cache line is four bus words
`define REFILL_LINE_WORDS 4
`define REFILL_LINE_W (`REFILL_DATA_W * `REFILL_LINE_WORDS)

// miss requests waiting for the bus
`define REFILL_QUEUE_DEPTH 4

`endif

//--- refill_line_assembler.sv
`timescale 1ns/100ps
`include "refill_defines.svh"

module refill_line_assembler (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     beat_valid,
    input  refill_pkg::refill_beat_t beat,
    output logic                     ret_valid,
    output refill_pkg::refill_ret_t  ret
);
    import refill_pkg::*;

    localparam int DATA_W = `REFILL_DATA_W;

    refill_ret_t line_q;
    refill_ret_t line_next;

    // current beat dropped into its slot
    always_comb begin
        line_next = line_q;
        line_next.data[beat.index * DATA_W +: DATA_W] = beat.data;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            line_q    <= '0;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= beat_valid && beat.last;
            if (beat_valid) begin
                // start clean so a single word keeps zeros above it
                line_q <= beat.last ? '0 : line_next;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_valid && beat.last) begin
            ret <= line_next;
        end
    end

    // the bus gap after each request keeps returns apart
    ret_single_pulse: assert property (
        @(posedge aclk) disable iff (rst)
        ret_valid |=> !ret_valid
    );

endmodule

//--- refill_pkg.sv
`include "refill_defines.svh"

package refill_pkg;

    // miss request kind from the cache
    typedef enum logic {
        RD_WORD = 1'b0,
        RD_LINE = 1'b1
    } refill_kind_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUS  = 1'b1
    } reader_state_e;

    typedef struct packed {
        refill_kind_e               kind;
        logic [`REFILL_ADDR_W-1:0]  addr;
    } refill_req_t;

    // one word read from the bus, tagged with its slot in the line
    typedef struct packed {
        logic [`REFILL_DATA_W-1:0]              data;
        logic [$clog2(`REFILL_LINE_WORDS)-1:0]  index;
        logic                                   last;
    } refill_beat_t;

    typedef struct packed {
        logic [`REFILL_LINE_W-1:0]  data;
    } refill_ret_t;

endpackage

//--- refill_req_queue.sv
`timescale 1ns/100ps
`include "refill_defines.svh"

module refill_req_queue (
    input  logic                    aclk,
    input  logic                    rst,
    input  logic                    push,
    input  refill_pkg::refill_req_t push_cmd,
    input  logic                    q_pop,
    output logic                    push_rdy,
    output logic                    q_valid,
    output refill_pkg::refill_req_t q_head
);
    import refill_pkg::*;

    localparam int DEPTH = `REFILL_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    refill_req_t        mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push_acc;
    logic               pop_acc;

    // ready only looks at the fill level, never at push
    assign push_rdy = (count != CNT_W'(DEPTH));
    assign q_valid  = (count != '0);
    assign q_head   = mem[rd_ptr];

    assign push_acc = push && push_rdy;
    assign pop_acc  = q_pop && q_valid;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_acc) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_acc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_acc, pop_acc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push_acc) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    // reader must only pop a head that exists
    pop_not_empty: assert property (
        @(posedge aclk) disable iff (rst)
        q_pop |-> q_valid
    );

    // a push into a full queue would overrun the fill level
    count_in_range: assert property (
        @(posedge aclk) disable iff (rst)
        count <= CNT_W'(DEPTH)
    );

endmodule

//--- refill_top.sv
`timescale 1ns/100ps
`include "refill_defines.svh"

module refill_top (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       rd_req,
    input  refill_pkg::refill_req_t    rd_cmd,
    input  logic                       wb_ack,
    input  logic [`REFILL_DATA_W-1:0]  wb_dat_i,
    output logic                       rd_rdy,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic [`REFILL_ADDR_W-1:0]  wb_adr,
    output logic                       ret_valid,
    output refill_pkg::refill_ret_t    ret
);
    import refill_pkg::*;

    logic         q_valid;
    refill_req_t  q_head;
    logic         q_pop;
    logic         beat_valid;
    refill_beat_t beat;

    refill_req_queue u_queue (
        .aclk     (aclk    ),
        .rst      (rst     ),
        .push     (rd_req  ),
        .push_cmd (rd_cmd  ),
        .q_pop    (q_pop   ),
        .push_rdy (rd_rdy  ),
        .q_valid  (q_valid ),
        .q_head   (q_head  )
    );

    refill_bus_reader u_reader (
        .aclk       (aclk      ),
        .rst        (rst       ),
        .q_valid    (q_valid   ),
        .q_head     (q_head    ),
        .wb_ack     (wb_ack    ),
        .wb_dat_i   (wb_dat_i  ),
        .q_pop      (q_pop     ),
        .wb_cyc     (wb_cyc    ),
        .wb_stb     (wb_stb    ),
        .wb_adr     (wb_adr    ),
        .beat_valid (beat_valid),
        .beat       (beat      )
    );

    refill_line_assembler u_assembler (
        .aclk       (aclk      ),
        .rst        (rst       ),
        .beat_valid (beat_valid),
        .beat       (beat      ),
        .ret_valid  (ret_valid ),
        .ret        (ret       )
    );

endmodule

//--- tb_refill_top.sv
`timescale 1ns/100ps
`include "refill_defines.svh"

module tb_refill_top #(
    parameter int SEED = 32'h07c0_93e7
);
    import refill_pkg::*;

    localparam int          NUM_REQS    = 200;
    localparam int          SLOW_REQS   = 50;
    localparam int          REQ_TIMEOUT = 200;
    localparam int          END_TIMEOUT = 2000;
    localparam int          DATA_W      = `REFILL_DATA_W;
    localparam logic [31:0] DATA_MUL    = 32'h9e37_79b9;
    localparam logic [31:0] DATA_ADD    = 32'h1234_5678;

    logic                      aclk;
    logic                      rst;
    logic                      rd_req;
    refill_req_t               rd_cmd;
    logic                      rd_rdy;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic [`REFILL_ADDR_W-1:0] wb_adr;
    logic                      wb_ack;
    logic [`REFILL_DATA_W-1:0] wb_dat_i;
    logic                      ret_valid;
    refill_ret_t               ret;
    logic                      slow_ack;

    integer                    seed;
    refill_ret_t               exp_ret_q [$];
    logic [`REFILL_ADDR_W-1:0] exp_adr_q [$];
    int                        num_ret;
    int                        num_waiting;
    logic                      cyc_prev;
    logic                      stall_seen;
    logic [`REFILL_ADDR_W-1:0] stall_adr;
    logic                      full_seen;

    refill_top DUT (
        .aclk      (aclk     ),
        .rst       (rst      ),
        .rd_req    (rd_req   ),
        .rd_cmd    (rd_cmd   ),
        .wb_ack    (wb_ack   ),
        .wb_dat_i  (wb_dat_i ),
        .rd_rdy    (rd_rdy   ),
        .wb_cyc    (wb_cyc   ),
        .wb_stb    (wb_stb   ),
        .wb_adr    (wb_adr   ),
        .ret_valid (ret_valid),
        .ret       (ret      )
    );

    tb_wb_mem #(
        .SEED     (SEED + 1),
        .DATA_MUL (DATA_MUL),
        .DATA_ADD (DATA_ADD)
    ) u_mem (
        .aclk   (aclk    ),
        .rst    (rst     ),
        .slow   (slow_ack),
        .wb_cyc (wb_cyc  ),
        .wb_stb (wb_stb  ),
        .wb_adr (wb_adr  ),
        .wb_ack (wb_ack  ),
        .wb_dat (wb_dat_i)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_ret(input refill_ret_t got, input refill_ret_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL ret got %h expected %h", got.data, exp.data));
        end
    endtask

    task automatic check_adr(input string name, input logic [`REFILL_ADDR_W-1:0] got,
                             input logic [`REFILL_ADDR_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // memory content as seen by the cache
    function automatic logic [31:0] word_at(input logic [31:0] word_adr);
        return word_adr * DATA_MUL + DATA_ADD;
    endfunction

    function automatic void expect_request(input refill_req_t cmd);
        refill_ret_t exp;
        logic [31:0] base;
        exp = '0;
        if (cmd.kind == RD_LINE) begin
            base = {cmd.addr[31:4], 4'h0};
            for (int i = 0; i < `REFILL_LINE_WORDS; i++) begin
                exp.data[i*DATA_W +: DATA_W] = word_at((base >> 2) + i);
                exp_adr_q.push_back(base + 32'(4 * i));
            end
        end else begin
            base = {cmd.addr[31:2], 2'b00};
            exp.data[DATA_W-1:0] = word_at(base >> 2);
            exp_adr_q.push_back(base);
        end
        exp_ret_q.push_back(exp);
    endfunction

    function automatic refill_req_t random_req();
        refill_req_t cmd;
        cmd.kind = ($random(seed) & 1) ? RD_LINE : RD_WORD;
        cmd.addr = $random(seed);
        return cmd;
    endfunction

    // hold the request until the edge that takes it
    task automatic send_req(input refill_req_t cmd);
        int waited;
        waited = 0;
        rd_req = 1'b1;
        rd_cmd = cmd;
        while (!rd_rdy && waited < REQ_TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        if (!rd_rdy) begin
            abort_run("rd_rdy never came back for a pending request");
        end else begin
            @(negedge aclk);
            rd_req = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_ret_q.size() != 0 && waited < END_TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        if (exp_ret_q.size() != 0) begin
            abort_run("returns still missing after the drain timeout");
        end
    endtask

    // bus and return monitor
    always @(posedge aclk) begin
        if (!rst) begin
            // a bus cycle starts one edge after its request left the queue
            if (wb_cyc && !cyc_prev) begin
                num_waiting--;
            end
            cyc_prev = wb_cyc;
            check_bit("rd_rdy", rd_rdy, num_waiting != `REFILL_QUEUE_DEPTH);
            if (!rd_rdy) begin
                full_seen = 1'b1;
            end
            if (rd_req && rd_rdy) begin
                expect_request(rd_cmd);
                num_waiting++;
            end
            if (wb_stb) begin
                check_bit("wb_cyc", wb_cyc, 1'b1);
            end
            // a stalled strobe keeps its address
            if (stall_seen) begin
                check_bit("wb_stb", wb_stb, 1'b1);
                check_adr("wb_adr", wb_adr, stall_adr);
            end
            stall_seen = wb_stb && !wb_ack;
            stall_adr  = wb_adr;
            if (wb_stb && wb_ack) begin
                if (exp_adr_q.size() == 0) begin
                    abort_run("Wishbone beat with no request outstanding");
                end else begin
                    check_adr("wb_adr", wb_adr, exp_adr_q.pop_front());
                end
            end
            if (ret_valid) begin
                if (exp_ret_q.size() == 0) begin
                    abort_run("ret_valid with no request outstanding");
                end else begin
                    check_ret(ret, exp_ret_q.pop_front());
                    num_ret++;
                end
            end
        end
    end

    initial begin
        int gap;
        seed        = SEED;
        rst         = 1'b1;
        rd_req      = 1'b0;
        rd_cmd      = '0;
        slow_ack    = 1'b0;
        num_ret     = 0;
        num_waiting = 0;
        cyc_prev    = 1'b0;
        stall_seen  = 1'b0;
        stall_adr   = '0;
        full_seen   = 1'b0;
        repeat (8) @(negedge aclk);
        rst = 1'b0;
        // idle outputs before any request
        repeat (3) begin
            @(negedge aclk);
            check_bit("rd_rdy", rd_rdy, 1'b1);
            check_bit("wb_cyc", wb_cyc, 1'b0);
            check_bit("wb_stb", wb_stb, 1'b0);
            check_bit("ret_valid", ret_valid, 1'b0);
        end
        for (int n = 0; n < NUM_REQS; n++) begin
            // last stretch runs back to back against a slow slave
            if (n == NUM_REQS - SLOW_REQS) begin
                slow_ack = 1'b1;
            end
            send_req(random_req());
            if (!slow_ack) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge aclk);
            end
        end
        wait_drain();
        if (full_seen && num_ret == NUM_REQS && exp_ret_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("run ended with missing returns or without rd_rdy falling");
        end
    end

endmodule

//--- tb_wb_mem.sv
`timescale 1ns/100ps
`include "refill_defines.svh"

module tb_wb_mem #(
    parameter int          SEED     = 1,
    parameter logic [31:0] DATA_MUL = '0,
    parameter logic [31:0] DATA_ADD = '0
) (
    input  logic                      aclk,
    input  logic                      rst,
    input  logic                      slow,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic [`REFILL_ADDR_W-1:0] wb_adr,
    output logic                      wb_ack,
    output logic [`REFILL_DATA_W-1:0] wb_dat
);

    integer seed;
    int     delay_left;
    logic   armed;

    // classic slave, one beat per ack, outputs change on the falling edge
    initial begin
        seed       = SEED;
        wb_ack     = 1'b0;
        wb_dat     = '0;
        armed      = 1'b0;
        delay_left = 0;
        forever begin
            @(negedge aclk);
            if (rst) begin
                wb_ack = 1'b0;
                armed  = 1'b0;
            end else if (wb_ack) begin
                // beat taken on the last rising edge
                wb_ack = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!armed) begin
                    delay_left = $unsigned($random(seed)) % 4;
                    if (slow) begin
                        delay_left = delay_left + 6;
                    end
                    armed = 1'b1;
                end
                if (delay_left == 0) begin
                    wb_ack = 1'b1;
                    wb_dat = (wb_adr >> 2) * DATA_MUL + DATA_ADD;
                    armed  = 1'b0;
                end else begin
                    delay_left = delay_left - 1;
                end
            end
        end
    end

endmodule
